// ==== rtl/trap_pkg.sv ====
/* Shared widths, CSR numbers and constant values of the machine-mode trap unit.
   Modules refer to these by scoped names. */
`default_nettype none

package trap_pkg;

    // Data and address widths.
    typedef logic [31:0] word_t;
    typedef logic [11:0] csr_num_t;
    typedef logic [31:0] pc_t;
    typedef logic [4:0]  cause_t;
    typedef logic [15:0] irq_t;
    typedef logic [1:0]  resp_t;

    // Bus port states.
    typedef enum logic [1:0] {idle, commit, write_resp, read_resp} axil_state_t;

    // External line 0 maps to cause 16.
    localparam int unsigned irq_base = 16;

    // Machine-mode CSR numbers.
    localparam csr_num_t csr_mstatus    = 12'h300;
    localparam csr_num_t csr_misa       = 12'h301;
    localparam csr_num_t csr_medeleg    = 12'h302;
    localparam csr_num_t csr_mideleg    = 12'h303;
    localparam csr_num_t csr_mie        = 12'h304;
    localparam csr_num_t csr_mtvec      = 12'h305;
    localparam csr_num_t csr_mstatush   = 12'h310;
    localparam csr_num_t csr_mscratch   = 12'h340;
    localparam csr_num_t csr_mepc       = 12'h341;
    localparam csr_num_t csr_mcause     = 12'h342;
    localparam csr_num_t csr_mtval      = 12'h343;
    localparam csr_num_t csr_mip        = 12'h344;
    // Identity CSRs, read only.
    localparam csr_num_t csr_mvendorid  = 12'hf11;
    localparam csr_num_t csr_marchid    = 12'hf12;
    localparam csr_num_t csr_mimpid     = 12'hf13;
    localparam csr_num_t csr_mhartid    = 12'hf14;
    localparam csr_num_t csr_mconfigptr = 12'hf15;

    // MXL 1, extensions I and M.
    localparam word_t misa_value = 32'h4000_1100;
    localparam word_t hart_id    = 32'h0000_0000;

    // Bits kept in mstatus.
    localparam int unsigned mstatus_mie_bit  = 3;
    localparam int unsigned mstatus_mpie_bit = 7;

    // AXI responses.
    localparam resp_t resp_okay   = 2'b00;
    localparam resp_t resp_slverr = 2'b10;

endpackage

`default_nettype wire

// ==== rtl/csr_bus_if.sv ====
/* One CSR access from the bus port to the CSR file.
   Strobes last one cycle, read data and error answer in the same cycle. */
`timescale 1ns/1ns
`default_nettype none

interface csr_bus_if;
    // CSR number and write data.
    trap_pkg::csr_num_t addr;
    trap_pkg::word_t    wdata;
    // Access strobes.
    logic               we;
    logic               re;
    // Combinational answer.
    trap_pkg::word_t    rdata;
    logic               err;

    // Bus port side.
    modport port (output addr, output wdata, output we, output re,
                  input rdata, input err);

    // CSR file side.
    modport file (input addr, input wdata, input we, input re,
                  output rdata, output err);
endinterface

`default_nettype wire

// ==== rtl/trap_if.sv ====
/* Trap events from the trap control to the CSR file, and CSR state back.
   The file side also flags a busy cycle for the bus port. */
`timescale 1ns/1ns
`default_nettype none

interface trap_if;
    // Trap or interrupt entry.
    logic             take;
    logic             is_int;
    trap_pkg::cause_t cause;
    trap_pkg::pc_t    epc;
    // Return from trap.
    logic             mret_take;

    // CSR state seen by the trap control.
    logic             global_ie;
    trap_pkg::word_t  ie_mask;
    trap_pkg::pc_t    mtvec;
    trap_pkg::pc_t    mepc;
    // High while an event updates the CSRs.
    logic             busy;

    modport control (output take, output is_int, output cause, output epc,
                     output mret_take,
                     input global_ie, input ie_mask, input mtvec, input mepc);

    modport file (input take, input is_int, input cause, input epc,
                  input mret_take,
                  output global_ie, output ie_mask, output mtvec, output mepc,
                  output busy);
endinterface

`default_nettype wire

// ==== rtl/axil_csr_port.sv ====
/* AXI4-Lite slave that turns bus transfers into single CSR accesses.
   Full-word writes only; writes wait while a trap event is busy. */
`timescale 1ns/1ns
`default_nettype none

module axil_csr_port (
    input  logic              clk,
    input  logic              rst_latch,

    // Write address and data.
    input  trap_pkg::word_t   awaddr,
    input  logic              awvalid,
    output logic              awready,
    input  trap_pkg::word_t   wdata,
    input  logic              wvalid,
    output logic              wready,
    // Write response.
    output trap_pkg::resp_t   bresp,
    output logic              bvalid,
    input  logic              bready,
    // Read channel.
    input  trap_pkg::word_t   araddr,
    input  logic              arvalid,
    output logic              arready,
    output trap_pkg::word_t   rdata,
    output trap_pkg::resp_t   rresp,
    output logic              rvalid,
    input  logic              rready,

    csr_bus_if.port           csr,
    input  logic              busy
);
    trap_pkg::axil_state_t state;
    // Captured write request.
    trap_pkg::csr_num_t    addr_q;
    trap_pkg::word_t       wdata_q;
    // Registered answer.
    trap_pkg::word_t       rdata_q;
    trap_pkg::resp_t       resp_q;

    // Address and data only together.
    assign awready = (state == trap_pkg::idle) && awvalid && wvalid;
    assign wready  = awready;
    // Read only when no write is pending.
    assign arready = (state == trap_pkg::idle) && arvalid && !awvalid && !wvalid;

    assign bvalid = (state == trap_pkg::write_resp);
    assign bresp  = resp_q;
    assign rvalid = (state == trap_pkg::read_resp);
    assign rresp  = resp_q;
    assign rdata  = rdata_q;

    // Reads use the live address, writes the captured one.
    assign csr.addr  = (state == trap_pkg::idle) ? araddr[13:2] : addr_q;
    assign csr.wdata = wdata_q;
    assign csr.re    = arready;
    // Held back during a trap event.
    assign csr.we    = (state == trap_pkg::commit) && !busy;

    always_ff @(posedge clk) begin
        if (rst_latch) begin
            state <= trap_pkg::idle;
        end else begin
            case (state)
                trap_pkg::idle: begin
                    if (awready) begin
                        state <= trap_pkg::commit;
                    end else if (arready) begin
                        state <= trap_pkg::read_resp;
                    end
                end
                trap_pkg::commit: begin
                    if (!busy) begin
                        state <= trap_pkg::write_resp;
                    end
                end
                trap_pkg::write_resp: begin
                    if (bready) begin
                        state <= trap_pkg::idle;
                    end
                end
                default: begin
                    if (rready) begin
                        state <= trap_pkg::idle;
                    end
                end
            endcase
        end
    end

    // Request and response payload.
    always_ff @(posedge clk) begin
        if (awready) begin
            addr_q  <= awaddr[13:2];
            wdata_q <= wdata;
        end
        if (arready) begin
            rdata_q <= csr.rdata;
        end
        if (arready || csr.we) begin
            resp_q <= csr.err ? trap_pkg::resp_slverr : trap_pkg::resp_okay;
        end
    end

endmodule

`default_nettype wire

// ==== rtl/irq_arbiter.sv ====
/* Picks the lowest-numbered external interrupt that is pending and enabled. */
`timescale 1ns/1ns
`default_nettype none

module irq_arbiter (
    input  trap_pkg::irq_t   irq,
    input  trap_pkg::word_t  ie_mask,
    output logic             pending,
    output trap_pkg::cause_t cause
);
    trap_pkg::word_t lines;

    // External lines sit above the standard causes.
    assign lines   = (trap_pkg::word_t'(irq) << trap_pkg::irq_base) & ie_mask;
    assign pending = |lines;

    always_comb begin
        cause = '0;
        // Downward scan, so the lowest line wins.
        for (int i = 31; i >= 0; i--) begin
            if (lines[i]) begin
                cause = trap_pkg::cause_t'(i);
            end
        end
    end

endmodule

`default_nettype wire

// ==== rtl/trap_control.sv ====
/* Chooses between exception, MRET and interrupt each cycle.
   Event strobes are combinational, the fetch redirect is registered. */
`timescale 1ns/1ns
`default_nettype none

module trap_control (
    input  logic             clk,
    input  logic             rst_latch,

    input  logic             exc_valid,
    input  trap_pkg::cause_t exc_cause,
    input  trap_pkg::pc_t    pc,
    input  logic             mret,
    input  trap_pkg::irq_t   irq,

    trap_if.control          tr,

    output logic             redirect_valid,
    output trap_pkg::pc_t    redirect_pc
);
    logic             irq_pending;
    trap_pkg::cause_t irq_cause;

    irq_arbiter i_irq_arbiter (
        .irq     (irq),
        .ie_mask (tr.ie_mask),
        .pending (irq_pending),
        .cause   (irq_cause)
    );

    // Exception first, then MRET, then interrupt.
    always_comb begin
        tr.take      = 1'b0;
        tr.is_int    = 1'b0;
        tr.cause     = exc_cause;
        tr.epc       = pc;
        tr.mret_take = 1'b0;
        if (exc_valid) begin
            tr.take = 1'b1;
        end else if (mret) begin
            tr.mret_take = 1'b1;
        end else if (irq_pending && tr.global_ie) begin
            // Interrupts need global enable.
            tr.take   = 1'b1;
            tr.is_int = 1'b1;
            tr.cause  = irq_cause;
        end
    end

    // One-cycle redirect pulse.
    always_ff @(posedge clk) begin
        if (rst_latch) begin
            redirect_valid <= 1'b0;
        end else begin
            redirect_valid <= tr.take || tr.mret_take;
        end
    end

    // Vector on entry, saved PC on return.
    always_ff @(posedge clk) begin
        redirect_pc <= tr.take ? tr.mtvec : tr.mepc;
    end

endmodule

`default_nettype wire

// ==== rtl/csr_file.sv ====
/* Machine-mode CSR storage with read decode and access checks.
   Trap entry and MRET update the CSRs ahead of bus writes. */
`timescale 1ns/1ns
`default_nettype none

module csr_file (
    input  logic           clk,
    input  logic           rst_latch,
    input  trap_pkg::irq_t irq,
    csr_bus_if.file        bus,
    trap_if.file           tr
);
    // mstatus keeps only the two enable bits.
    logic             mstatus_mie_q;
    logic             mstatus_mpie_q;
    trap_pkg::word_t  mie_q;
    logic [31:2]      mtvec_q;
    trap_pkg::word_t  mscratch_q;
    logic [31:1]      mepc_q;
    logic             mcause_int_q;
    trap_pkg::cause_t mcause_no_q;

    trap_pkg::word_t  mstatus_val;
    trap_pkg::word_t  rdata;
    logic             known;
    logic             read_only;

    always_comb begin
        mstatus_val = '0;
        mstatus_val[trap_pkg::mstatus_mie_bit]  = mstatus_mie_q;
        mstatus_val[trap_pkg::mstatus_mpie_bit] = mstatus_mpie_q;
    end

    // Read decode.
    always_comb begin
        rdata     = '0;
        known     = 1'b1;
        read_only = 1'b0;
        case (bus.addr)
            trap_pkg::csr_mstatus:  rdata = mstatus_val;
            trap_pkg::csr_misa:     rdata = trap_pkg::misa_value;
            trap_pkg::csr_medeleg,
            trap_pkg::csr_mideleg,
            trap_pkg::csr_mstatush,
            trap_pkg::csr_mtval:    rdata = '0;
            trap_pkg::csr_mie:      rdata = mie_q;
            trap_pkg::csr_mtvec:    rdata = {mtvec_q, 2'b00};
            // Live interrupt lines.
            trap_pkg::csr_mip:      rdata = trap_pkg::word_t'(irq) << trap_pkg::irq_base;
            trap_pkg::csr_mscratch: rdata = mscratch_q;
            trap_pkg::csr_mepc:     rdata = {mepc_q, 1'b0};
            trap_pkg::csr_mcause:   rdata = {mcause_int_q, 26'd0, mcause_no_q};
            trap_pkg::csr_mhartid: begin
                rdata     = trap_pkg::hart_id;
                read_only = 1'b1;
            end
            // Remaining identity CSRs read as zero.
            trap_pkg::csr_mvendorid,
            trap_pkg::csr_marchid,
            trap_pkg::csr_mimpid,
            trap_pkg::csr_mconfigptr: read_only = 1'b1;
            default:                  known = 1'b0;
        endcase
    end

    assign bus.rdata = rdata;
    // Unknown number, or write to an identity CSR.
    assign bus.err   = (bus.we || bus.re) && (!known || (bus.we && read_only));

    // State for the trap control.
    assign tr.global_ie = mstatus_mie_q;
    assign tr.ie_mask   = mie_q;
    assign tr.mtvec     = {mtvec_q, 2'b00};
    assign tr.mepc      = {mepc_q, 1'b0};
    assign tr.busy      = tr.take || tr.mret_take;

    always_ff @(posedge clk) begin
        if (rst_latch) begin
            mstatus_mie_q  <= 1'b0;
            mstatus_mpie_q <= 1'b0;
            mie_q          <= '0;
            mtvec_q        <= '0;
            mscratch_q     <= '0;
            mepc_q         <= '0;
            mcause_int_q   <= 1'b0;
            mcause_no_q    <= '0;
        end else if (tr.take) begin
            // Trap entry.
            mepc_q         <= tr.epc[31:1];
            mcause_int_q   <= tr.is_int;
            mcause_no_q    <= tr.cause;
            mstatus_mpie_q <= mstatus_mie_q;
            mstatus_mie_q  <= 1'b0;
        end else if (tr.mret_take) begin
            // Return restores the enable.
            mstatus_mie_q  <= mstatus_mpie_q;
            mstatus_mpie_q <= 1'b1;
        end else if (bus.we) begin
            // Write-ignored CSRs fall through.
            case (bus.addr)
                trap_pkg::csr_mstatus: begin
                    mstatus_mie_q  <= bus.wdata[trap_pkg::mstatus_mie_bit];
                    mstatus_mpie_q <= bus.wdata[trap_pkg::mstatus_mpie_bit];
                end
                trap_pkg::csr_mie:      mie_q      <= bus.wdata;
                trap_pkg::csr_mtvec:    mtvec_q    <= bus.wdata[31:2];
                trap_pkg::csr_mscratch: mscratch_q <= bus.wdata;
                trap_pkg::csr_mepc:     mepc_q     <= bus.wdata[31:1];
                trap_pkg::csr_mcause: begin
                    mcause_int_q <= bus.wdata[31];
                    mcause_no_q  <= bus.wdata[4:0];
                end
                default: ;
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== rtl/m_trap_unit.sv ====
/* Top level of the machine-mode trap and CSR unit.
   AXI4-Lite CSR access, trap inputs and a fetch redirect on plain ports. */
`timescale 1ns/1ns
`default_nettype none

module m_trap_unit (
    input  logic             clk,
    input  logic             rst_latch,

    // AXI4-Lite CSR access.
    input  trap_pkg::word_t  awaddr,
    input  logic             awvalid,
    output logic             awready,
    input  trap_pkg::word_t  wdata,
    input  logic             wvalid,
    output logic             wready,
    output trap_pkg::resp_t  bresp,
    output logic             bvalid,
    input  logic             bready,
    input  trap_pkg::word_t  araddr,
    input  logic             arvalid,
    output logic             arready,
    output trap_pkg::word_t  rdata,
    output trap_pkg::resp_t  rresp,
    output logic             rvalid,
    input  logic             rready,

    // Trap events from the pipeline.
    input  logic             exc_valid,
    input  trap_pkg::cause_t exc_cause,
    input  trap_pkg::pc_t    pc,
    input  logic             mret,
    input  trap_pkg::irq_t   irq,

    // Toward fetch.
    output logic             redirect_valid,
    output trap_pkg::pc_t    redirect_pc
);
    csr_bus_if csr_bus ();
    trap_if    tr ();

    axil_csr_port i_axil_csr_port (
        .clk     (clk),
        .rst_latch (rst_latch),
        .awaddr  (awaddr),
        .awvalid (awvalid),
        .awready (awready),
        .wdata   (wdata),
        .wvalid  (wvalid),
        .wready  (wready),
        .bresp   (bresp),
        .bvalid  (bvalid),
        .bready  (bready),
        .araddr  (araddr),
        .arvalid (arvalid),
        .arready (arready),
        .rdata   (rdata),
        .rresp   (rresp),
        .rvalid  (rvalid),
        .rready  (rready),
        .csr     (csr_bus.port),
        // Writes wait out trap events.
        .busy    (tr.busy)
    );

    trap_control i_trap_control (
        .clk            (clk),
        .rst_latch      (rst_latch),
        .exc_valid      (exc_valid),
        .exc_cause      (exc_cause),
        .pc             (pc),
        .mret           (mret),
        .irq            (irq),
        .tr             (tr.control),
        .redirect_valid (redirect_valid),
        .redirect_pc    (redirect_pc)
    );

    csr_file i_csr_file (
        .clk       (clk),
        .rst_latch (rst_latch),
        .irq       (irq),
        .bus       (csr_bus.file),
        .tr        (tr.file)
    );

endmodule

`default_nettype wire

// ==== testbench/m_trap_unit_assertions.sv ====
/* Handshake checks on the AXI4-Lite CSR port.
   Bound into every axil_csr_port instance. */
`timescale 1ns/1ns
`default_nettype none

module m_trap_unit_assertions (
    input logic            clk,
    input logic            rst_latch,
    input logic            awready,
    input logic            arready,
    input logic            bvalid,
    input logic            bready,
    input trap_pkg::resp_t bresp,
    input logic            rvalid,
    input logic            rready,
    input trap_pkg::word_t rdata,
    input trap_pkg::resp_t rresp
);
    // Write response stays up and unchanged until bready.
    bresp_held: assert property (@(posedge clk) disable iff (rst_latch)
        bvalid && !bready |=> bvalid && $stable(bresp))
        else $error("Write response dropped or changed before bready.");

    // Same for the read data and response.
    rdata_held: assert property (@(posedge clk) disable iff (rst_latch)
        rvalid && !rready |=> rvalid && $stable(rdata) && $stable(rresp))
        else $error("Read response dropped or changed before rready.");

    // Read answer in the cycle after acceptance.
    read_answer: assert property (@(posedge clk) disable iff (rst_latch)
        arready |=> rvalid)
        else $error("Read accepted without a response at the next edge.");

    // Accepted write spends at least one cycle in commit.
    write_commit: assert property (@(posedge clk) disable iff (rst_latch)
        awready |=> !bvalid && !rvalid)
        else $error("Response raised right after a write was accepted.");

endmodule

bind axil_csr_port m_trap_unit_assertions i_port_assertions (
    .clk       (clk),
    .rst_latch (rst_latch),
    .awready   (awready),
    .arready   (arready),
    .bvalid    (bvalid),
    .bready    (bready),
    .bresp     (bresp),
    .rvalid    (rvalid),
    .rready    (rready),
    .rdata     (rdata),
    .rresp     (rresp)
);

`default_nettype wire

// ==== testbench/m_trap_unit_tb.sv ====
/* Random testbench for the trap unit with LFSR stimulus on the AXI4-Lite port and trap inputs.
   A cycle model of the CSRs predicts read data, responses and every redirect. */
`timescale 1ns/1ns
`default_nettype none

module m_trap_unit_tb;
    localparam int op_count       = 400;
    localparam int timeout_cycles = op_count * 24;

    logic clk;
    logic rst_latch;
    trap_pkg::word_t  awaddr;
    logic             awvalid;
    logic             awready;
    trap_pkg::word_t  wdata;
    logic             wvalid;
    logic             wready;
    trap_pkg::resp_t  bresp;
    logic             bvalid;
    logic             bready;
    trap_pkg::word_t  araddr;
    logic             arvalid;
    logic             arready;
    trap_pkg::word_t  rdata;
    trap_pkg::resp_t  rresp;
    logic             rvalid;
    logic             rready;
    logic             exc_valid;
    trap_pkg::cause_t exc_cause;
    trap_pkg::pc_t    pc;
    logic             mret;
    trap_pkg::irq_t   irq;
    logic             redirect_valid;
    trap_pkg::pc_t    redirect_pc;

    // Reference CSR state, full words with storage masks applied.
    trap_pkg::word_t m_mstatus;
    trap_pkg::word_t m_mie;
    trap_pkg::word_t m_mtvec;
    trap_pkg::word_t m_mscratch;
    trap_pkg::word_t m_mepc;
    trap_pkg::word_t m_mcause;
    logic            exp_redirect_valid;
    trap_pkg::pc_t   exp_redirect_pc;
    // Accepted writes waiting to land.
    int              wr_issued = 0;
    int              wr_done = 0;
    trap_pkg::csr_num_t wr_num;
    trap_pkg::word_t wr_data;
    logic [31:0]     lfsr_q = 32'hb06a;
    int              ready_hold = 0;
    int              cycles = 0;

    m_trap_unit i_m_trap_unit (.*);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // Fibonacci LFSR with taps 32 22 2 1 and one step per bit.
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        logic        fb;
        r = '0;
        for (int i = 0; i < n; i++) begin
            fb = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
            lfsr_q = {lfsr_q[30:0], fb};
            r = {r[30:0], fb};
        end
        return r;
    endfunction

    task automatic check_value(input string what, input logic [31:0] got,
                               input logic [31:0] want);
        if (got !== want) begin
            $display("Error at %0t ns: %s is %h, expected %h", $time, what, got, want);
            $display("Some tests failed");
            $fatal(1, "Mismatch on %s.", what);
        end
    endtask

    function automatic trap_pkg::csr_num_t pick_csr();
        case (4'(rand_bits(4)))
            4'd0:  return trap_pkg::csr_mstatus;
            4'd1:  return trap_pkg::csr_mie;
            4'd2:  return trap_pkg::csr_mtvec;
            4'd3:  return trap_pkg::csr_mscratch;
            4'd4:  return trap_pkg::csr_mepc;
            4'd5:  return trap_pkg::csr_mcause;
            4'd6:  return trap_pkg::csr_misa;
            4'd7:  return trap_pkg::csr_medeleg;
            4'd8:  return trap_pkg::csr_mideleg;
            4'd9:  return trap_pkg::csr_mstatush;
            4'd10: return trap_pkg::csr_mtval;
            4'd11: return trap_pkg::csr_mip;
            4'd12: return trap_pkg::csr_mconfigptr;
            // mvendorid up to mhartid.
            4'd13: return trap_pkg::csr_mvendorid + 12'(rand_bits(2));
            4'd14: return 12'h7c0;
            default: return 12'hb00;
        endcase
    endfunction

    // Expected read value before any update at this edge.
    function automatic trap_pkg::word_t model_read(input trap_pkg::csr_num_t num);
        case (num)
            trap_pkg::csr_mstatus:  return m_mstatus;
            trap_pkg::csr_misa:     return trap_pkg::misa_value;
            trap_pkg::csr_mie:      return m_mie;
            trap_pkg::csr_mtvec:    return m_mtvec;
            trap_pkg::csr_mscratch: return m_mscratch;
            trap_pkg::csr_mepc:     return m_mepc;
            trap_pkg::csr_mcause:   return m_mcause;
            // External lines start at cause 16.
            trap_pkg::csr_mip:      return {irq, 16'h0000};
            trap_pkg::csr_mhartid:  return trap_pkg::hart_id;
            default:                return '0;
        endcase
    endfunction

    function automatic logic model_err(input trap_pkg::csr_num_t num, input logic is_write);
        logic identity;
        logic known;
        identity = (num >= trap_pkg::csr_mvendorid) && (num <= trap_pkg::csr_mconfigptr);
        known = identity || (num inside {trap_pkg::csr_mstatus, trap_pkg::csr_misa,
            trap_pkg::csr_medeleg, trap_pkg::csr_mideleg, trap_pkg::csr_mie,
            trap_pkg::csr_mtvec, trap_pkg::csr_mstatush, trap_pkg::csr_mip,
            trap_pkg::csr_mscratch, trap_pkg::csr_mepc, trap_pkg::csr_mcause,
            trap_pkg::csr_mtval});
        return !known || (is_write && identity);
    endfunction

    // Cycle model with event priority ahead of a waiting bus write.
    always @(posedge clk) begin
        logic             take;
        logic             is_int;
        logic             found;
        trap_pkg::cause_t cause;
        trap_pkg::irq_t   lines;
        if (rst_latch) begin
            m_mstatus = '0;
            m_mie = '0;
            m_mtvec = '0;
            m_mscratch = '0;
            m_mepc = '0;
            m_mcause = '0;
            exp_redirect_valid = 1'b0;
        end else begin
            take = exc_valid;
            is_int = 1'b0;
            found = 1'b0;
            cause = exc_cause;
            lines = irq & m_mie[31:16];
            if (!exc_valid && !mret && m_mstatus[trap_pkg::mstatus_mie_bit]) begin
                for (int i = 0; i < 16; i++) begin
                    if (!found && lines[i]) begin
                        found = 1'b1;
                        cause = trap_pkg::cause_t'(trap_pkg::irq_base + i);
                    end
                end
                take = found;
                is_int = found;
            end
            exp_redirect_valid = take || (mret && !exc_valid);
            exp_redirect_pc = take ? m_mtvec : m_mepc;
            if (take) begin
                m_mepc = pc & 32'hffff_fffe;
                m_mcause = {is_int, 26'd0, cause};
                // MPIE takes MIE, MIE clears.
                m_mstatus = m_mstatus[trap_pkg::mstatus_mie_bit] ? 32'h80 : 32'h00;
            end else if (mret) begin
                m_mstatus = m_mstatus[trap_pkg::mstatus_mpie_bit] ? 32'h88 : 32'h80;
            end else if (wr_issued != wr_done) begin
                case (wr_num)
                    trap_pkg::csr_mstatus:  m_mstatus = wr_data & 32'h0000_0088;
                    trap_pkg::csr_mie:      m_mie = wr_data;
                    trap_pkg::csr_mtvec:    m_mtvec = wr_data & 32'hffff_fffc;
                    trap_pkg::csr_mscratch: m_mscratch = wr_data;
                    trap_pkg::csr_mepc:     m_mepc = wr_data & 32'hffff_fffe;
                    trap_pkg::csr_mcause:   m_mcause = wr_data & 32'h8000_001f;
                    default: ;
                endcase
                wr_done = wr_done + 1;
            end
        end
    end

    // Redirect is stable mid-cycle.
    always @(negedge clk) begin
        if (!rst_latch) begin
            check_value("redirect_valid", 32'(redirect_valid), 32'(exp_redirect_valid));
            if (exp_redirect_valid) begin
                check_value("redirect_pc", redirect_pc, exp_redirect_pc);
            end
        end
    end

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles > timeout_cycles) begin
            $display("Timeout: the run did not finish within %0d cycles.", timeout_cycles);
            $display("Some tests failed");
            $fatal(1, "Timeout.");
        end
    end

    task automatic write_csr(input trap_pkg::csr_num_t num, input trap_pkg::word_t data);
        trap_pkg::resp_t exp_resp;
        exp_resp = model_err(num, 1'b1) ? trap_pkg::resp_slverr : trap_pkg::resp_okay;
        awaddr = {18'(rand_bits(18)), num, 2'(rand_bits(2))};
        wdata = data;
        awvalid = 1'b1;
        wvalid = 1'b1;
        @(negedge clk);
        while (!awready) @(negedge clk);
        check_value("wready", 32'(wready), 32'd1);
        @(posedge clk);
        #1;
        awvalid = 1'b0;
        wvalid = 1'b0;
        wr_num = num;
        wr_data = data;
        wr_issued = wr_issued + 1;
        // Sometimes an exception lands in the commit cycle.
        if (rand_bits(2) == 0) begin
            exc_valid = 1'b1;
            exc_cause = trap_pkg::cause_t'(rand_bits(5));
            pc = rand_bits(32);
        end
        @(posedge clk);
        #1;
        exc_valid = 1'b0;
        @(negedge clk);
        while (!bvalid) @(negedge clk);
        check_value($sformatf("bresp of csr %h", num), 32'(bresp), 32'(exp_resp));
        repeat (ready_hold) begin
            @(negedge clk);
            check_value("bvalid while held", 32'(bvalid), 32'd1);
        end
        @(posedge clk);
        #1;
        bready = 1'b1;
        @(posedge clk);
        #1;
        bready = 1'b0;
    endtask

    task automatic read_csr(input trap_pkg::csr_num_t num);
        trap_pkg::word_t exp_data;
        trap_pkg::resp_t exp_resp;
        exp_resp = model_err(num, 1'b0) ? trap_pkg::resp_slverr : trap_pkg::resp_okay;
        araddr = {18'(rand_bits(18)), num, 2'(rand_bits(2))};
        arvalid = 1'b1;
        @(negedge clk);
        while (!arready) @(negedge clk);
        // Accepted at the coming edge.
        exp_data = model_read(num);
        @(posedge clk);
        #1;
        arvalid = 1'b0;
        @(negedge clk);
        while (!rvalid) @(negedge clk);
        check_value($sformatf("rresp of csr %h", num), 32'(rresp), 32'(exp_resp));
        if (exp_resp == trap_pkg::resp_okay) begin
            check_value($sformatf("rdata of csr %h", num), rdata, exp_data);
        end
        repeat (ready_hold) begin
            @(negedge clk);
            check_value("rvalid while held", 32'(rvalid), 32'd1);
        end
        @(posedge clk);
        #1;
        rready = 1'b1;
        @(posedge clk);
        #1;
        rready = 1'b0;
    endtask

    task automatic raise_exception();
        exc_valid = 1'b1;
        exc_cause = trap_pkg::cause_t'(rand_bits(5));
        pc = rand_bits(32);
        @(posedge clk);
        #1;
        exc_valid = 1'b0;
        read_csr(trap_pkg::csr_mstatus);
        read_csr(trap_pkg::csr_mepc);
        read_csr(trap_pkg::csr_mcause);
    endtask

    task automatic issue_mret();
        mret = 1'b1;
        @(posedge clk);
        #1;
        mret = 1'b0;
        read_csr(trap_pkg::csr_mstatus);
    endtask

    // New irq level, a few idle cycles, then the cause.
    task automatic drive_irq();
        int unsigned idle_cycles;
        irq = trap_pkg::irq_t'(rand_bits(16));
        idle_cycles = rand_bits(2) + 1;
        repeat (idle_cycles) @(posedge clk);
        #1;
        read_csr(trap_pkg::csr_mcause);
    endtask

    initial begin
        logic [2:0]         op;
        trap_pkg::csr_num_t num;
        rst_latch = 1'b1;
        awaddr = '0;
        awvalid = 1'b0;
        wdata = '0;
        wvalid = 1'b0;
        bready = 1'b0;
        araddr = '0;
        arvalid = 1'b0;
        rready = 1'b0;
        exc_valid = 1'b0;
        exc_cause = '0;
        pc = '0;
        mret = 1'b0;
        irq = '0;
        repeat (5) @(posedge clk);
        #1;
        rst_latch = 1'b0;
        // Vector, all line enables and MIE, so interrupts can fire early.
        write_csr(trap_pkg::csr_mtvec, 32'h0000_1000);
        write_csr(trap_pkg::csr_mie, 32'hffff_0000);
        write_csr(trap_pkg::csr_mstatus, 32'h0000_0008);
        for (int n = 0; n < op_count; n++) begin
            op = 3'(rand_bits(3));
            case (op)
                3'd0: begin
                    num = pick_csr();
                    write_csr(num, rand_bits(32));
                    read_csr(num);
                end
                3'd1: write_csr(pick_csr(), rand_bits(32));
                3'd2, 3'd3: read_csr(pick_csr());
                3'd4: raise_exception();
                3'd5: issue_mret();
                3'd6: drive_irq();
                default: ready_hold = int'(rand_bits(2));
            endcase
        end
        repeat (4) @(posedge clk);
        $display("All tests passed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== sim.f ====
rtl/trap_pkg.sv
rtl/csr_bus_if.sv
rtl/trap_if.sv
rtl/axil_csr_port.sv
rtl/irq_arbiter.sv
rtl/trap_control.sv
rtl/csr_file.sv
rtl/m_trap_unit.sv
testbench/m_trap_unit_assertions.sv
testbench/m_trap_unit_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Builds the trap unit testbench with Verilator, runs it and looks for the pass message.

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert --timescale 1ns/1ns \
        --top-module m_trap_unit_tb -Mdir obj_dir -f sim.f; then
    echo "Verilator build failed"
    exit 1
fi

output=$(./obj_dir/Vm_trap_unit_tb)
status=$?
echo "$output"

if [ "$status" -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -q "^All tests passed$"; then
    exit 0
fi
exit 1
